// ==== common/prf_bank_if.sv ====
`timescale 1ns/1ps

interface prf_bank_if
    import prf_pkg::*;
();

    // read side
    upper_pr_t ren_index;
    data_t     rdata;

    // write side
    logic      wen;
    upper_pr_t windex;
    data_t     wdata;

    modport read_mp (
        output ren_index,
        input  rdata
    );

    modport write_mp (
        output wen,
        output windex,
        output wdata
    );

    modport ram_mp (
        input  ren_index,
        output rdata,
        input  wen,
        input  windex,
        input  wdata
    );

endinterface

// ==== common/prf_pkg.sv ====
package prf_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------

    // physical registers and banking
    localparam int PR_COUNT       = 64;
    localparam int LOG_PR_COUNT   = 6;
    localparam int BANK_COUNT     = 4;
    localparam int LOG_BANK_COUNT = 2;
    localparam int BANK_DEPTH     = PR_COUNT / BANK_COUNT;

    // requestor counts
    localparam int RR_COUNT = 4;
    localparam int WR_COUNT = 4;

    // register value width
    localparam int DATA_WIDTH = 32;

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------

    // full register number with the bank in the low bits
    typedef logic [LOG_PR_COUNT-1:0] pr_t;

    // entry inside a bank
    typedef logic [LOG_PR_COUNT-LOG_BANK_COUNT-1:0] upper_pr_t;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // 38 bit writeback payload
    typedef struct packed {
        pr_t   pr;
        data_t data;
    } wb_req_t;

endpackage

// ==== flist.f ====
common/prf_pkg.sv
common/prf_bank_if.sv
logic/bank_rr_arbiter.sv
logic/pending_req_buffer.sv
logic/prf_bank_ram.sv
read/prf_read_ctrl.sv
writeback/prf_wb_ctrl.sv
logic/prf.sv
test/prf_tb.sv

// ==== logic/bank_rr_arbiter.sv ====
`timescale 1ns/1ps

module bank_rr_arbiter
    import prf_pkg::*;
#(
    parameter int WIDTH = RR_COUNT
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] grant
);

    // requestors above the last grant
    logic [WIDTH-1:0] last_mask;
    logic [WIDTH-1:0] next_last_mask;

    logic [WIDTH-1:0] masked_req;
    logic [WIDTH-1:0] masked_grant;
    logic [WIDTH-1:0] unmasked_grant;

    // isolate the lowest set bit
    function automatic logic [WIDTH-1:0] lowest_one(input logic [WIDTH-1:0] vec);
        return vec & (~vec + WIDTH'(1));
    endfunction

    always_comb begin
        masked_req     = req & last_mask;
        masked_grant   = lowest_one(masked_req);
        unmasked_grant = lowest_one(req);

        // masked search wins when anything sits above the last grant
        if (|masked_req) begin
            grant = masked_grant;
        end else begin
            grant = unmasked_grant;
        end

        // every bit above the granted one, or none without a grant
        next_last_mask = '0;
        for (int i = 1; i < WIDTH; i++) begin
            next_last_mask[i] = grant[i-1] | next_last_mask[i-1];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            last_mask <= '0;
        end else begin
            last_mask <= next_last_mask;
        end
    end

endmodule

// ==== logic/pending_req_buffer.sv ====
`timescale 1ns/1ps

module pending_req_buffer
    import prf_pkg::*;
#(
    parameter type payload_t = pr_t
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     in_valid,
    input  payload_t in_payload,
    input  logic     granted,
    output logic     req_valid,
    output payload_t req_payload,
    output logic     pending
);

    logic     pend_valid;
    payload_t pend_payload;

    // held request shadows the inputs
    assign req_valid   = pend_valid | in_valid;
    assign req_payload = pend_valid ? pend_payload : in_payload;
    assign pending     = pend_valid;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= req_valid & ~granted;
        end
    end

    // capture only what lost arbitration
    always_ff @(posedge CLK) begin
        if (req_valid && !granted) begin
            pend_payload <= req_payload;
        end
    end

endmodule

// ==== logic/prf.sv ====
`timescale 1ns/1ps

module prf
    import prf_pkg::*;
(
    input  logic                          CLK,
    input  logic                          nRST,

    // reads
    input  logic      [RR_COUNT-1:0]      read_req_valid,
    input  pr_t       [RR_COUNT-1:0]      read_req_pr,
    output logic      [RR_COUNT-1:0]      read_resp_valid,
    output data_t     [RR_COUNT-1:0]      read_resp_data,

    // writeback requests
    input  logic      [WR_COUNT-1:0]      wb_valid,
    input  pr_t       [WR_COUNT-1:0]      wb_pr,
    input  data_t     [WR_COUNT-1:0]      wb_data,
    output logic      [WR_COUNT-1:0]      wb_ready,

    // per bank announcement and forward
    output logic      [BANK_COUNT-1:0]    wb_bus_valid,
    output upper_pr_t [BANK_COUNT-1:0]    wb_bus_upper_pr,
    output data_t     [BANK_COUNT-1:0]    forward_data
);

    prf_bank_if bank_if [BANK_COUNT] ();

    prf_read_ctrl read_ctrl (
        .CLK            (CLK),
        .nRST           (nRST),
        .read_req_valid (read_req_valid),
        .read_req_pr    (read_req_pr),
        .read_resp_valid(read_resp_valid),
        .read_resp_data (read_resp_data),
        .bank           (bank_if)
    );

    prf_wb_ctrl wb_ctrl (
        .CLK            (CLK),
        .nRST           (nRST),
        .wb_valid       (wb_valid),
        .wb_pr          (wb_pr),
        .wb_data        (wb_data),
        .wb_ready       (wb_ready),
        .wb_bus_valid   (wb_bus_valid),
        .wb_bus_upper_pr(wb_bus_upper_pr),
        .forward_data   (forward_data),
        .bank           (bank_if)
    );

    // one storage array per bank
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_ram
        prf_bank_ram ram (
            .CLK (CLK),
            .port(bank_if[b])
        );
    end

endmodule

// ==== logic/prf_bank_ram.sv ====
`timescale 1ns/1ps

module prf_bank_ram
    import prf_pkg::*;
(
    input  logic          CLK,
    prf_bank_if.ram_mp    port
);

    // one bank worth of registers
    data_t mem [BANK_DEPTH];

    // write at the clock edge
    always_ff @(posedge CLK) begin
        if (port.wen) begin
            mem[port.windex] <= port.wdata;
        end
    end

    // read is combinational from the index register
    assign port.rdata = mem[port.ren_index];

endmodule

// ==== read/prf_read_ctrl.sv ====
`timescale 1ns/1ps

module prf_read_ctrl
    import prf_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [RR_COUNT-1:0]       read_req_valid,
    input  pr_t  [RR_COUNT-1:0]       read_req_pr,
    output logic [RR_COUNT-1:0]       read_resp_valid,
    output data_t [RR_COUNT-1:0]      read_resp_data,
    prf_bank_if.read_mp               bank [BANK_COUNT]
);

    // effective request per requestor
    logic [RR_COUNT-1:0] eff_valid;
    pr_t  [RR_COUNT-1:0] eff_pr;
    logic [RR_COUNT-1:0] rr_granted;

    logic [RR_COUNT-1:0] req_by_bank   [BANK_COUNT];
    logic [RR_COUNT-1:0] grant_by_bank [BANK_COUNT];

    upper_pr_t next_ren_index [BANK_COUNT];
    upper_pr_t ren_index_q    [BANK_COUNT];
    data_t     bank_rdata     [BANK_COUNT];

    // bank that serves each response
    logic [LOG_BANK_COUNT-1:0] resp_bank [RR_COUNT];

    // ------------------------------------------------------------------------
    // per requestor hold
    // ------------------------------------------------------------------------

    for (genvar r = 0; r < RR_COUNT; r++) begin : g_rr
        pending_req_buffer #(
            .payload_t(pr_t)
        ) req_buf (
            .CLK        (CLK),
            .nRST       (nRST),
            .in_valid   (read_req_valid[r]),
            .in_payload (read_req_pr[r]),
            .granted    (rr_granted[r]),
            .req_valid  (eff_valid[r]),
            .req_payload(eff_pr[r]),
            .pending    ()
        );
    end

    // ------------------------------------------------------------------------
    // bank demux and arbitration
    // ------------------------------------------------------------------------

    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int r = 0; r < RR_COUNT; r++) begin
                req_by_bank[b][r] = eff_valid[r] &&
                    (eff_pr[r][LOG_BANK_COUNT-1:0] == LOG_BANK_COUNT'(b));
            end
        end
    end

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        bank_rr_arbiter #(
            .WIDTH(RR_COUNT)
        ) arb (
            .CLK  (CLK),
            .nRST (nRST),
            .req  (req_by_bank[b]),
            .grant(grant_by_bank[b])
        );

        assign bank[b].ren_index = ren_index_q[b];
        assign bank_rdata[b]     = bank[b].rdata;
    end

    always_comb begin
        rr_granted = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            rr_granted = rr_granted | grant_by_bank[b];
        end

        // one-hot pick of the granted entry index
        for (int b = 0; b < BANK_COUNT; b++) begin
            next_ren_index[b] = '0;
            for (int r = 0; r < RR_COUNT; r++) begin
                next_ren_index[b] |= eff_pr[r][LOG_PR_COUNT-1:LOG_BANK_COUNT]
                    & {(LOG_PR_COUNT-LOG_BANK_COUNT){grant_by_bank[b][r]}};
            end
        end
    end

    // ------------------------------------------------------------------------
    // index register and response
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK) begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            ren_index_q[b] <= next_ren_index[b];
        end
        for (int r = 0; r < RR_COUNT; r++) begin
            resp_bank[r] <= eff_pr[r][LOG_BANK_COUNT-1:0];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            read_resp_valid <= '0;
        end else begin
            read_resp_valid <= rr_granted;
        end
    end

    // data comes straight off the bank that was granted
    always_comb begin
        for (int r = 0; r < RR_COUNT; r++) begin
            read_resp_data[r] = bank_rdata[resp_bank[r]];
        end
    end

endmodule

// ==== test/prf_tb.sv ====
`timescale 1ns/1ps

module prf_tb
    import prf_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 5;
    localparam int RAND_SEED     = 32'hbf72;
    localparam int RANDOM_CYCLES = 300;

    // fill, read back, conflict, register 0, random traffic
    localparam int OP_COUNT       = 63 + 63 + 4 + 1 + RANDOM_CYCLES;
    localparam int TIMEOUT_CYCLES = OP_COUNT * 8 + 50;

    logic                       CLK;
    logic                       nRST;
    logic      [RR_COUNT-1:0]   read_req_valid;
    pr_t       [RR_COUNT-1:0]   read_req_pr;
    logic      [RR_COUNT-1:0]   read_resp_valid;
    data_t     [RR_COUNT-1:0]   read_resp_data;
    logic      [WR_COUNT-1:0]   wb_valid;
    pr_t       [WR_COUNT-1:0]   wb_pr;
    data_t     [WR_COUNT-1:0]   wb_data;
    logic      [WR_COUNT-1:0]   wb_ready;
    logic      [BANK_COUNT-1:0] wb_bus_valid;
    upper_pr_t [BANK_COUNT-1:0] wb_bus_upper_pr;
    data_t     [BANK_COUNT-1:0] forward_data;

    // reference state
    data_t model       [PR_COUNT];
    data_t issued_data [PR_COUNT];
    bit    inflight    [PR_COUNT];
    int    ann_cycle   [PR_COUNT];
    int    rd_cnt      [PR_COUNT];
    int    ann_count   [BANK_COUNT];
    data_t fwd_expect  [BANK_COUNT];
    bit    fwd_due     [BANK_COUNT];

    // outstanding reads per requestor
    logic [RR_COUNT-1:0] rd_busy;
    pr_t                 rd_pr [RR_COUNT];

    int    cycle;
    int    error_count;
    int    check_count;
    string test_name;

    prf UUT (
        .CLK            (CLK),
        .nRST           (nRST),
        .read_req_valid (read_req_valid),
        .read_req_pr    (read_req_pr),
        .read_resp_valid(read_resp_valid),
        .read_resp_data (read_resp_data),
        .wb_valid       (wb_valid),
        .wb_pr          (wb_pr),
        .wb_data        (wb_data),
        .wb_ready       (wb_ready),
        .wb_bus_valid   (wb_bus_valid),
        .wb_bus_upper_pr(wb_bus_upper_pr),
        .forward_data   (forward_data)
    );

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    // ------------------------------------------------------------------------
    // reference model and checking helpers
    // ------------------------------------------------------------------------

    function automatic data_t expected_read(input pr_t pr);
        return model[pr];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic note_failure(input string msg);
        error_count++;
        $display("%s: %s", test_name, msg);
    endtask

    function automatic int inflight_count();
        int n;
        n = 0;
        for (int i = 0; i < PR_COUNT; i++) begin
            n += inflight[i];
        end
        return n;
    endfunction

    // no write in flight and no read waiting on it
    function automatic bit can_write(input pr_t pr);
        return (pr != '0) && !inflight[pr] && (rd_cnt[pr] == 0);
    endfunction

    // last write announced two or more cycles ago
    function automatic bit can_read(input pr_t pr);
        return (pr != '0) && !inflight[pr] && (ann_cycle[pr] + 2 <= cycle);
    endfunction

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------

    task automatic next_cycle();
        @(posedge CLK);
        #DRIVE_DELAY;
        wb_valid       = '0;
        read_req_valid = '0;
    endtask

    task automatic issue_write(input int w, input pr_t pr, input data_t value);
        wb_valid[w] = 1'b1;
        wb_pr[w]    = pr;
        wb_data[w]  = value;
        if (pr != '0) begin
            inflight[pr]    = 1'b1;
            issued_data[pr] = value;
        end
    endtask

    task automatic issue_read(input int r, input pr_t pr);
        read_req_valid[r] = 1'b1;
        read_req_pr[r]    = pr;
        rd_busy[r]        = 1'b1;
        rd_pr[r]          = pr;
        rd_cnt[pr]++;
    endtask

    task automatic drain_writes();
        while (wb_ready != '1) begin
            next_cycle();
        end
        repeat (2) next_cycle();
        if (inflight_count() != 0) begin
            note_failure($sformatf("%0d writes were never announced", inflight_count()));
        end
    endtask

    task automatic drain_reads();
        while (rd_busy != '0) begin
            next_cycle();
        end
    endtask

    // ------------------------------------------------------------------------
    // writeback bus, forwarding and read response monitor
    // ------------------------------------------------------------------------

    always @(negedge CLK) begin : bus_monitor
        pr_t ann_pr;
        if (nRST) begin
            // forward data trails the announcement by one cycle
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (fwd_due[b]) begin
                    check_value({test_name, " forward"}, fwd_expect[b], forward_data[b]);
                    fwd_due[b] = 1'b0;
                end
            end
            for (int b = 0; b < BANK_COUNT; b++) begin
                if (wb_bus_valid[b]) begin
                    ann_pr = {wb_bus_upper_pr[b], LOG_BANK_COUNT'(b)};
                    ann_count[b]++;
                    if (!inflight[ann_pr]) begin
                        note_failure($sformatf("register %0d announced with no write outstanding",
                                               ann_pr));
                    end else begin
                        model[ann_pr]     = issued_data[ann_pr];
                        inflight[ann_pr]  = 1'b0;
                        ann_cycle[ann_pr] = cycle;
                        fwd_expect[b]     = issued_data[ann_pr];
                        fwd_due[b]        = 1'b1;
                    end
                end
            end
            for (int r = 0; r < RR_COUNT; r++) begin
                if (read_resp_valid[r]) begin
                    if (!rd_busy[r]) begin
                        note_failure($sformatf(
                            "read requestor %0d responded with no read outstanding", r));
                    end else begin
                        check_value({test_name, " read data"}, expected_read(rd_pr[r]),
                                    read_resp_data[r]);
                        rd_busy[r] = 1'b0;
                        rd_cnt[rd_pr[r]]--;
                    end
                end
            end
        end
    end

    // watchdog sized from the operation count
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d clock periods", TIMEOUT_CYCLES);
        $display("errors: %0d, checks: %0d", error_count, check_count);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin : stimulus
        int    next_pr;
        int    ann_before;
        pr_t   pick;
        void'($urandom(RAND_SEED));
        nRST           = 1'b0;
        read_req_valid = '0;
        read_req_pr    = '0;
        wb_valid       = '0;
        wb_pr          = '0;
        wb_data        = '0;
        rd_busy        = '0;
        cycle          = 0;
        error_count    = 0;
        check_count    = 0;
        test_name      = "reset";
        for (int i = 0; i < PR_COUNT; i++) begin
            model[i]     = '0;
            issued_data[i] = '0;
            inflight[i]  = 1'b0;
            ann_cycle[i] = 0;
            rd_cnt[i]    = 0;
        end
        for (int b = 0; b < BANK_COUNT; b++) begin
            ann_count[b]  = 0;
            fwd_due[b]    = 1'b0;
            fwd_expect[b] = '0;
        end

        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        nRST = 1'b1;
        check_value("reset wb_ready", 32'({WR_COUNT{1'b1}}), 32'(wb_ready));
        check_value("reset wb_bus_valid", '0, 32'(wb_bus_valid));
        check_value("reset read_resp_valid", '0, 32'(read_resp_valid));
        for (int b = 0; b < BANK_COUNT; b++) begin
            check_value("reset forward_data", '0, forward_data[b]);
        end
        next_cycle();

        // fill registers 1 to 63 with the register number in the top byte
        test_name = "write_read_back";
        next_pr = 1;
        while (next_pr < PR_COUNT) begin
            for (int w = 0; w < WR_COUNT; w++) begin
                if (wb_ready[w] && next_pr < PR_COUNT) begin
                    issue_write(w, pr_t'(next_pr), {8'(next_pr), 24'($urandom)});
                    next_pr++;
                end
            end
            next_cycle();
        end
        drain_writes();
        next_pr = 1;
        while (next_pr < PR_COUNT) begin
            for (int r = 0; r < RR_COUNT; r++) begin
                if (!rd_busy[r] && next_pr < PR_COUNT) begin
                    issue_read(r, pr_t'(next_pr));
                    next_pr++;
                end
            end
            next_cycle();
        end
        drain_reads();

        // all writers hit bank 2 so grants rotate from 0 to 3
        test_name = "bank_conflict";
        ann_before = ann_count[2];
        for (int w = 0; w < WR_COUNT; w++) begin
            issue_write(w, pr_t'((w + 1) * BANK_COUNT + 2), $urandom);
        end
        next_cycle();
        for (int k = 0; k < WR_COUNT; k++) begin
            check_value({test_name, " wb_ready"}, (32'd1 << (k + 1)) - 1, 32'(wb_ready));
            next_cycle();
        end
        drain_writes();
        check_value({test_name, " announcements"}, WR_COUNT, ann_count[2] - ann_before);

        test_name = "register_zero";
        ann_before = ann_count[0];
        issue_write(1, '0, $urandom);
        next_cycle();
        check_value({test_name, " wb_ready"}, 1, 32'(wb_ready[1]));
        repeat (3) next_cycle();
        check_value({test_name, " announcements"}, ann_before, ann_count[0]);

        test_name = "random_traffic";
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            for (int w = 0; w < WR_COUNT; w++) begin
                pick = pr_t'($urandom_range(PR_COUNT - 1, 1));
                if (wb_ready[w] && ($urandom % 2) && can_write(pick)) begin
                    issue_write(w, pick, $urandom);
                end
            end
            for (int r = 0; r < RR_COUNT; r++) begin
                pick = pr_t'($urandom_range(PR_COUNT - 1, 1));
                if (!rd_busy[r] && ($urandom % 2) && can_read(pick)) begin
                    issue_read(r, pick);
                end
            end
            next_cycle();
        end
        drain_writes();
        drain_reads();
        repeat (2) next_cycle();

        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== writeback/prf_wb_ctrl.sv ====
`timescale 1ns/1ps

module prf_wb_ctrl
    import prf_pkg::*;
(
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic      [WR_COUNT-1:0]      wb_valid,
    input  pr_t       [WR_COUNT-1:0]      wb_pr,
    input  data_t     [WR_COUNT-1:0]      wb_data,
    output logic      [WR_COUNT-1:0]      wb_ready,
    output logic      [BANK_COUNT-1:0]    wb_bus_valid,
    output upper_pr_t [BANK_COUNT-1:0]    wb_bus_upper_pr,
    output data_t     [BANK_COUNT-1:0]    forward_data,
    prf_bank_if.write_mp                  bank [BANK_COUNT]
);

    wb_req_t [WR_COUNT-1:0] in_req;
    wb_req_t [WR_COUNT-1:0] eff_req;
    logic    [WR_COUNT-1:0] eff_valid;
    logic    [WR_COUNT-1:0] wr_pending;
    logic    [WR_COUNT-1:0] wr_granted;

    logic [WR_COUNT-1:0] req_by_bank   [BANK_COUNT];
    logic [WR_COUNT-1:0] grant_by_bank [BANK_COUNT];

    // granted payload per bank
    wb_req_t sel_req [BANK_COUNT];

    logic      [BANK_COUNT-1:0] next_wen;
    logic      [BANK_COUNT-1:0] wen_q;
    upper_pr_t [BANK_COUNT-1:0] windex_q;
    data_t     [BANK_COUNT-1:0] wdata_q;

    // ------------------------------------------------------------------------
    // per writer hold
    // ------------------------------------------------------------------------

    for (genvar w = 0; w < WR_COUNT; w++) begin : g_wr
        assign in_req[w] = '{pr: wb_pr[w], data: wb_data[w]};

        pending_req_buffer #(
            .payload_t(wb_req_t)
        ) req_buf (
            .CLK        (CLK),
            .nRST       (nRST),
            .in_valid   (wb_valid[w]),
            .in_payload (in_req[w]),
            .granted    (wr_granted[w]),
            .req_valid  (eff_valid[w]),
            .req_payload(eff_req[w]),
            .pending    (wr_pending[w])
        );
    end

    // stalled writers see ready low
    assign wb_ready = ~wr_pending;

    // ------------------------------------------------------------------------
    // bank demux, arbitration and merge
    // ------------------------------------------------------------------------

    always_comb begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int w = 0; w < WR_COUNT; w++) begin
                req_by_bank[b][w] = eff_valid[w] &&
                    (eff_req[w].pr[LOG_BANK_COUNT-1:0] == LOG_BANK_COUNT'(b));
            end
        end
    end

    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        bank_rr_arbiter #(
            .WIDTH(WR_COUNT)
        ) arb (
            .CLK  (CLK),
            .nRST (nRST),
            .req  (req_by_bank[b]),
            .grant(grant_by_bank[b])
        );

        assign bank[b].wen    = wen_q[b];
        assign bank[b].windex = windex_q[b];
        assign bank[b].wdata  = wdata_q[b];
    end

    always_comb begin
        wr_granted = '0;
        for (int b = 0; b < BANK_COUNT; b++) begin
            wr_granted = wr_granted | grant_by_bank[b];
        end

        for (int b = 0; b < BANK_COUNT; b++) begin
            sel_req[b] = '0;
            for (int w = 0; w < WR_COUNT; w++) begin
                sel_req[b] = sel_req[b]
                    | (eff_req[w] & {$bits(wb_req_t){grant_by_bank[b][w]}});
            end
            // register 0 is never stored or announced
            next_wen[b] = (|grant_by_bank[b]) && (sel_req[b].pr != '0);
        end
    end

    // ------------------------------------------------------------------------
    // bank write, writeback bus and forwarding
    // ------------------------------------------------------------------------

    always_ff @(posedge CLK) begin
        for (int b = 0; b < BANK_COUNT; b++) begin
            windex_q[b] <= sel_req[b].pr[LOG_PR_COUNT-1:LOG_BANK_COUNT];
            wdata_q[b]  <= sel_req[b].data;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wen_q        <= '0;
            forward_data <= '0;
        end else begin
            wen_q        <= next_wen;
            // one cycle behind the announcement
            forward_data <= wdata_q;
        end
    end

    assign wb_bus_valid    = wen_q;
    assign wb_bus_upper_pr = windex_q;

endmodule
